// File: design/cu_macros.svh
`ifndef CU_MACROS_SVH
`define CU_MACROS_SVH

//////////////////////////////
// datapath widths
//////////////////////////////

`define CU_SAMPLE_W   16 // one q15 component
`define CU_PROD_W     33 // slice product, room for a sum of two
`define CU_OP_W       2  // opcode field

//////////////////////////////
// pipeline and buffer
//////////////////////////////

`define CU_FIFO_DEPTH 8 // result entries, also initial sender credits
`define CU_PIPE_LAT   4 // accepted input to buffer write

`endif

// File: design/cu_pkg.sv
`default_nettype none

`include "cu_macros.svh"

package cu_pkg;

	//////////////////////////////
	// data types
	//////////////////////////////

	typedef logic signed [`CU_SAMPLE_W-1:0] sample_t; // q15 re or im
	typedef logic [2*`CU_SAMPLE_W-1:0] cword_t; // {re, im}
	typedef logic signed [`CU_PROD_W-1:0] prod_t; // slice output

	//////////////////////////////
	// opcodes
	//////////////////////////////

	typedef enum logic [`CU_OP_W-1:0] {
		OP_CMUL  = 2'd0, // x * y
		OP_CMULJ = 2'd1, // x * conj(y)
		OP_PASS  = 2'd2, // y unchanged
		OP_ZERO  = 2'd3  // reserved, result zero
	} cu_op_e;

endpackage

`default_nettype wire

// File: design/slice_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

// per-operation controls for one multiplier slice
interface slice_ctrl_if;

	logic valid;   // operation in flight
	logic usemult; // 1 multiply, 0 pass a << 15
	logic negate;  // negate slice result
	logic zero;    // force slice result to 0

	modport decoder (
		output valid, usemult, negate, zero
	);

	modport slice (
		input valid, usemult, negate, zero
	);

endinterface

`default_nettype wire

// File: design/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  logic            in_valid_i, // operation accepted this cycle
	input  cu_pkg::cu_op_e  op_i,
	slice_ctrl_if.decoder   ctrl_1_o, // re*re
	slice_ctrl_if.decoder   ctrl_2_o, // im*im
	slice_ctrl_if.decoder   ctrl_3_o, // im*re
	slice_ctrl_if.decoder   ctrl_4_o  // re*im
);

	import cu_pkg::*;

	logic [3:0] usemult_w; // bit 0 is slice 1
	logic [3:0] negate_w;
	logic [3:0] zero_w;

	always_comb begin
		usemult_w = 4'b1111; // multiply by default
		negate_w  = 4'b0000;
		zero_w    = 4'b0000;
		case (op_i)
			OP_CMUL:  negate_w = 4'b0010; // I = rr - ii
			OP_CMULJ: negate_w = 4'b1000; // Q = ir - ri
			OP_PASS: begin
				usemult_w = 4'b0000; // shift path on 1 and 4
				zero_w    = 4'b0110; // cross terms off
			end
			default: zero_w = 4'b1111; // OP_ZERO and anything else
		endcase
	end

	assign ctrl_1_o.valid   = in_valid_i;
	assign ctrl_1_o.usemult = usemult_w[0];
	assign ctrl_1_o.negate  = negate_w[0];
	assign ctrl_1_o.zero    = zero_w[0];

	assign ctrl_2_o.valid   = in_valid_i;
	assign ctrl_2_o.usemult = usemult_w[1];
	assign ctrl_2_o.negate  = negate_w[1];
	assign ctrl_2_o.zero    = zero_w[1];

	assign ctrl_3_o.valid   = in_valid_i;
	assign ctrl_3_o.usemult = usemult_w[2];
	assign ctrl_3_o.negate  = negate_w[2];
	assign ctrl_3_o.zero    = zero_w[2];

	assign ctrl_4_o.valid   = in_valid_i;
	assign ctrl_4_o.usemult = usemult_w[3];
	assign ctrl_4_o.negate  = negate_w[3];
	assign ctrl_4_o.zero    = zero_w[3];

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cu_macros.svh"

module alu (
	input  logic            clk,
	input  logic            arst_n_i,
	input  cu_pkg::sample_t a_i, // y half
	input  cu_pkg::sample_t b_i, // x half
	slice_ctrl_if.slice     ctrl,
	output cu_pkg::prod_t   p_o,
	output logic            p_valid_o
);

	import cu_pkg::*;

	//////////////////////////////
	// stage 1, operand registers
	//////////////////////////////

	sample_t a_q, b_q;
	logic    valid_1, usemult_1, negate_1, zero_1;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_1 <= 1'b0;
			usemult_1 <= 1'b0;
			negate_1 <= 1'b0;
			zero_1 <= 1'b0;
		end else begin
			valid_1 <= ctrl.valid;
			usemult_1 <= ctrl.usemult;
			negate_1 <= ctrl.negate;
			zero_1 <= ctrl.zero;
		end
	end

	always_ff @(posedge clk) begin
		a_q <= a_i;
		b_q <= b_i;
	end

	//////////////////////////////
	// stage 2, product register
	//////////////////////////////

	logic signed [2*`CU_SAMPLE_W-1:0] mul_w; // full 16x16 product
	prod_t   prod_d, prod_q;
	logic    valid_2, negate_2, zero_2;

	assign mul_w  = a_q * b_q;
	assign prod_d = usemult_1 ? prod_t'(mul_w)
	                          : (prod_t'(a_q) <<< (`CU_SAMPLE_W - 1)); // a in q30

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_2 <= 1'b0;
			negate_2 <= 1'b0;
			zero_2 <= 1'b0;
		end else begin
			valid_2 <= valid_1;
			negate_2 <= negate_1;
			zero_2 <= zero_1;
		end
	end

	always_ff @(posedge clk) prod_q <= prod_d;

	//////////////////////////////
	// stage 3, output register
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) p_valid_o <= 1'b0;
		else p_valid_o <= valid_2;
	end

	always_ff @(posedge clk) begin
		if (zero_2) p_o <= '0; // slice switched off
		else if (negate_2) p_o <= -prod_q; // |prod| <= 2^30, no overflow
		else p_o <= prod_q;
	end

endmodule

`default_nettype wire

// File: design/complex_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cu_macros.svh"

module complex_alu (
	input  logic            clk,
	input  logic            arst_n_i,
	slice_ctrl_if.slice     ctrl_1,
	slice_ctrl_if.slice     ctrl_2,
	slice_ctrl_if.slice     ctrl_3,
	slice_ctrl_if.slice     ctrl_4,
	input  cu_pkg::cword_t  din_1_i, // x
	input  cu_pkg::cword_t  din_2_i, // y
	output cu_pkg::cword_t  dout_o,
	output logic            dout_valid_o
);

	import cu_pkg::*;

	// round half up at bit 15 and clip to 16 bits
	function automatic sample_t round_sat(input prod_t sum);
		prod_t rnd;
		logic [`CU_PROD_W-`CU_SAMPLE_W:0] top; // bits above the result msb
		rnd = (sum + prod_t'(1 <<< (`CU_SAMPLE_W - 2))) >>> (`CU_SAMPLE_W - 1);
		top = rnd[`CU_PROD_W-1:`CU_SAMPLE_W-1];
		if (top == '0 || top == '1) return rnd[`CU_SAMPLE_W-1:0]; // in range
		else if (rnd[`CU_PROD_W-1]) return {1'b1, {(`CU_SAMPLE_W-1){1'b0}}}; // -32768
		else return {1'b0, {(`CU_SAMPLE_W-1){1'b1}}}; // 32767
	endfunction

	sample_t x_re, x_im, y_re, y_im;
	prod_t   p_1, p_2, p_3, p_4;
	logic    p_valid;
	prod_t   i_sum, q_sum;

	assign x_re = din_1_i[2*`CU_SAMPLE_W-1:`CU_SAMPLE_W];
	assign x_im = din_1_i[`CU_SAMPLE_W-1:0];
	assign y_re = din_2_i[2*`CU_SAMPLE_W-1:`CU_SAMPLE_W];
	assign y_im = din_2_i[`CU_SAMPLE_W-1:0];

	//////////////////////////////
	// multiplier slices
	//////////////////////////////

	// x on b, y on a
	alu core_1 (.clk(clk), .arst_n_i(arst_n_i), .a_i(y_re), .b_i(x_re), .ctrl(ctrl_1),
		.p_o(p_1), .p_valid_o(p_valid));
	alu core_2 (.clk(clk), .arst_n_i(arst_n_i), .a_i(y_im), .b_i(x_im), .ctrl(ctrl_2),
		.p_o(p_2), .p_valid_o());
	alu core_3 (.clk(clk), .arst_n_i(arst_n_i), .a_i(y_re), .b_i(x_im), .ctrl(ctrl_3),
		.p_o(p_3), .p_valid_o());
	alu core_4 (.clk(clk), .arst_n_i(arst_n_i), .a_i(y_im), .b_i(x_re), .ctrl(ctrl_4),
		.p_o(p_4), .p_valid_o());

	//////////////////////////////
	// combine, round, saturate
	//////////////////////////////

	assign i_sum = p_1 + p_2; // sign already set by decoder
	assign q_sum = p_3 + p_4;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) dout_valid_o <= 1'b0;
		else dout_valid_o <= p_valid; // all slices in lockstep
	end

	always_ff @(posedge clk) dout_o <= {round_sat(i_sum), round_sat(q_sum)};

endmodule

`default_nettype wire

// File: design/result_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "cu_macros.svh"

module result_fifo (
	input  logic           clk,
	input  logic           arst_n_i,
	input  logic           wr_valid_i,
	input  cu_pkg::cword_t wr_data_i,
	input  logic           out_credit_i, // one receiver credit per pulse
	output logic           credit_o,     // one sender credit per pulse
	output logic           dout_valid_o,
	output cu_pkg::cword_t dout_o
);

	import cu_pkg::*;

	localparam int PTR_W  = $clog2(`CU_FIFO_DEPTH);
	localparam int CNT_W  = $clog2(`CU_FIFO_DEPTH + 1);
	localparam int CRED_W = 8; // receiver credits held, saturating

	cword_t            mem [`CU_FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr, rd_ptr;
	logic [CNT_W-1:0]  count;   // occupancy
	logic [CRED_W-1:0] cred_cnt;
	logic              pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(`CU_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1; // wrap
	endfunction

	assign pop = (count != '0) && (cred_cnt != '0); // entry and credit both held

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			cred_cnt <= '0;
			dout_valid_o <= 1'b0;
			credit_o <= 1'b0;
		end else begin
			if (wr_valid_i) wr_ptr <= ptr_inc(wr_ptr);
			if (pop) rd_ptr <= ptr_inc(rd_ptr);
			case ({wr_valid_i, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // both or neither
			endcase
			case ({out_credit_i, pop})
				2'b10: if (cred_cnt != '1) cred_cnt <= cred_cnt + 1'b1;
				2'b01: cred_cnt <= cred_cnt - 1'b1;
				default: ; // grant and spend cancel
			endcase
			dout_valid_o <= pop; // single cycle per entry
			credit_o <= pop; // slot freed upstream
		end
	end

	always_ff @(posedge clk) begin
		if (wr_valid_i) mem[wr_ptr] <= wr_data_i;
		if (pop) dout_o <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

// File: design/cmplx_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module cmplx_unit_top (
	input  logic           clk,
	input  logic           arst_n_i,
	input  logic           in_valid_i, // spends one sender credit
	input  cu_pkg::cu_op_e op_i,
	input  cu_pkg::cword_t din_1_i,    // x
	input  cu_pkg::cword_t din_2_i,    // y
	output logic           credit_o,
	input  logic           out_credit_i,
	output logic           dout_valid_o,
	output cu_pkg::cword_t dout_o
);

	import cu_pkg::*;

	cword_t alu_dout;
	logic   alu_dout_valid;

	slice_ctrl_if ctrl_1 ();
	slice_ctrl_if ctrl_2 ();
	slice_ctrl_if ctrl_3 ();
	slice_ctrl_if ctrl_4 ();

	//////////////////////////////
	// decode, compute, buffer
	//////////////////////////////

	inst_decoder u_inst_decoder (
		.in_valid_i (in_valid_i),
		.op_i       (op_i),
		.ctrl_1_o   (ctrl_1),
		.ctrl_2_o   (ctrl_2),
		.ctrl_3_o   (ctrl_3),
		.ctrl_4_o   (ctrl_4)
	);

	complex_alu u_complex_alu (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.ctrl_1       (ctrl_1),
		.ctrl_2       (ctrl_2),
		.ctrl_3       (ctrl_3),
		.ctrl_4       (ctrl_4),
		.din_1_i      (din_1_i),
		.din_2_i      (din_2_i),
		.dout_o       (alu_dout),
		.dout_valid_o (alu_dout_valid)
	);

	result_fifo u_result_fifo (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.wr_valid_i   (alu_dout_valid), // slot already reserved by credit
		.wr_data_i    (alu_dout),
		.out_credit_i (out_credit_i),
		.credit_o     (credit_o),
		.dout_valid_o (dout_valid_o),
		.dout_o       (dout_o)
	);

endmodule

`default_nettype wire

// File: sim/tb_cmplx_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cu_macros.svh"

module tb_cmplx_unit;

	import cu_pkg::*;

	localparam int N_RAND = 150; // ops per random phase
	localparam int N_OPS = `CU_FIFO_DEPTH + 4 + 3 * N_RAND + 10;
	localparam int CYCLE_LIMIT = N_OPS * 40 + 1000;

	logic   clk = 1'b0;
	logic   arst_n_i, in_valid_i, out_credit_i, credit_o, dout_valid_o;
	cu_op_e op_i;
	cword_t din_1_i, din_2_i, dout_o;

	int seed = 32'h525fffc8;
	int credits = `CU_FIFO_DEPTH; // sender credits held
	int granted = 0;  // output credits handed out
	int received = 0; // results seen on dout_o
	int issue_pct, out_pct;
	int cycle_cnt = 0;

	cu_op_e op_q[$]; // stimulus not yet issued
	cword_t x_q[$], y_q[$];
	cword_t exp_q[$]; // issued, waiting for result

	cmplx_unit_top u_cmplx_unit_top (.clk(clk), .arst_n_i(arst_n_i), .in_valid_i(in_valid_i),
		.op_i(op_i), .din_1_i(din_1_i), .din_2_i(din_2_i), .credit_o(credit_o),
		.out_credit_i(out_credit_i), .dout_valid_o(dout_valid_o), .dout_o(dout_o));

	always #5 clk = ~clk; // 10 ns period

	//////////////////////////////
	// checks
	//////////////////////////////

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_cword(input string name, input cword_t got, input cword_t exp);
		if (got !== exp)
			stop_run($sformatf("FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic check_credit(input int held);
		if (held >= `CU_FIFO_DEPTH) stop_run("credit_o returned a credit the sender never spent");
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic sample_t q15_round(input longint acc);
		longint r;
		r = (acc + 64'sd16384) >>> 15; // half up at bit 15
		if (r > 32767) r = 32767;
		else if (r < -32768) r = -32768;
		return sample_t'(r);
	endfunction

	function automatic cword_t expected_cword(input cu_op_e op, input cword_t x, input cword_t y);
		longint xr, xi, yr, yi;
		xr = $signed(x[31:16]);
		xi = $signed(x[15:0]);
		yr = $signed(y[31:16]);
		yi = $signed(y[15:0]);
		case (op)
			OP_CMUL:  return {q15_round(xr * yr - xi * yi), q15_round(xi * yr + xr * yi)};
			OP_CMULJ: return {q15_round(xr * yr + xi * yi), q15_round(xi * yr - xr * yi)};
			OP_PASS:  return y; // y comes back untouched
			default:  return '0;
		endcase
	endfunction

	//////////////////////////////
	// stimulus
	//////////////////////////////

	function automatic int draw_pct();
		return int'($unsigned($random(seed)) % 100);
	endfunction

	task automatic queue_op(input cu_op_e op, input cword_t x, input cword_t y);
		op_q.push_back(op);
		x_q.push_back(x);
		y_q.push_back(y);
	endtask

	// mode 0 cmul only, 1 cmulj or pass, 2 any opcode
	task automatic queue_random(input int n, input int mode);
		logic [1:0] r;
		repeat (n) begin
			r = 2'($random(seed));
			if (mode == 0) r = 2'd0;
			else if (mode == 1) r = {~r[0], r[0]};
			queue_op(cu_op_e'(r), cword_t'($random(seed)), cword_t'($random(seed)));
		end
	endtask

	// check outputs then drive the next inputs at each falling edge
	task automatic step();
		@(negedge clk);
		check_bit("credit_o", credit_o, dout_valid_o); // one credit per result
		if (credit_o) begin
			check_credit(credits);
			credits++;
		end
		if (dout_valid_o) begin
			if (exp_q.size() == 0) stop_run("a result came out with no operation pending");
			if (granted <= received) stop_run("a result came out without an output credit");
			check_cword("dout_o", dout_o, exp_q.pop_front());
			received++;
		end
		out_credit_i = 1'b0;
		if (granted - received < 2 * `CU_FIFO_DEPTH && draw_pct() < out_pct) begin
			out_credit_i = 1'b1;
			granted++;
		end
		in_valid_i = 1'b0;
		if (op_q.size() != 0 && credits > 0 && draw_pct() < issue_pct) begin
			op_i = op_q.pop_front();
			din_1_i = x_q.pop_front();
			din_2_i = y_q.pop_front();
			exp_q.push_back(expected_cword(op_i, din_1_i, din_2_i));
			in_valid_i = 1'b1;
			credits--; // spent on issue
		end
	endtask

	task automatic run_ops(input int ipct, input int opct);
		issue_pct = ipct;
		out_pct = opct;
		while (op_q.size() != 0) step();
	endtask

	task automatic drain();
		issue_pct = 0;
		out_pct = 100;
		while (exp_q.size() != 0 || credits != `CU_FIFO_DEPTH) step();
	endtask

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) stop_run($sformatf("run timed out after %0d cycles", cycle_cnt));
	end

	initial begin
		arst_n_i = 1'b0;
		in_valid_i = 1'b0;
		out_credit_i = 1'b0;
		op_i = OP_CMUL;
		din_1_i = '0;
		din_2_i = '0;
		issue_pct = 0;
		out_pct = 0;
		repeat (10) @(negedge clk);
		arst_n_i = 1'b1;
		repeat (20) begin // quiet after reset
			step();
			check_bit("dout_valid_o", dout_valid_o, 1'b0);
		end
		queue_random(`CU_FIFO_DEPTH + 4, 2); // back-pressure with no output credits yet
		issue_pct = 100;
		while (credits != 0) step();
		repeat (3 * `CU_FIFO_DEPTH) step();
		run_ops(70, 50);
		drain();
		queue_random(N_RAND, 0); // cmul
		run_ops(75, 50);
		drain();
		queue_random(N_RAND, 1); // cmulj and pass
		run_ops(60, 80);
		drain();
		queue_op(OP_CMUL, 32'h80008000, 32'h80008000); // q saturates high
		queue_op(OP_CMULJ, 32'h80008000, 32'h80008000);
		queue_op(OP_PASS, 32'h7fff8001, 32'h80008000);
		queue_op(OP_ZERO, 32'hffffffff, 32'hffffffff);
		queue_op(OP_CMUL, 32'h80008000, 32'h7fff8000); // i saturates low
		queue_op(OP_CMULJ, 32'h7fff7fff, 32'h80007fff);
		queue_op(OP_PASS, 32'h00000000, 32'h7fff8001);
		queue_op(OP_CMUL, 32'h00010000, 32'h40000000); // +half rounds to 1
		queue_op(OP_CMUL, 32'hffff0000, 32'h40000000); // -half rounds to 0
		queue_op(OP_ZERO, 32'h12345678, 32'h9abcdef0);
		run_ops(100, 100);
		drain();
		queue_random(N_RAND, 2); // back to back
		run_ops(100, 100);
		drain();
		repeat (3 * `CU_FIFO_DEPTH) step(); // no stray result after the last one
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+design
design/cu_pkg.sv
design/slice_ctrl_if.sv
design/inst_decoder.sv
design/alu.sv
design/complex_alu.sv
design/result_fifo.sv
design/cmplx_unit_top.sv
sim/tb_cmplx_unit.sv

// File: Makefile
sim:
	verilator --binary --timing -Wno-fatal -f all.f --top-module tb_cmplx_unit
	./obj_dir/Vtb_cmplx_unit | tee sim.log
	grep -q "\*\* PASS \*\*" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
